// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// width of data, addresses, pc and instruction words
`define XLEN 32

// architectural integer registers, r0 included
`define NUM_REGS 32

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    // one machine word, used for data, pc and instruction words
    typedef logic [`XLEN-1:0] u32_t;

    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;  // index into the register file

    // access size of a load as handed over by the memory stage
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;  // code 3 is unused and treated as a word

endpackage

// File: rtl/wb_pass_if.sv
`timescale 1ns/1ps

interface wb_pass_if;
    import cpu_pkg::*;

    logic     valid;
    reg_idx_t rd;
    logic     is_wr_rd;
    logic     is_link;    // write pc plus 4 instead of result
    u32_t     pc;
    u32_t     inst;
    u32_t     result;     // loads arrive here already extended

    modport src (
        output valid, rd, is_wr_rd, is_link, pc, inst, result
    );

    modport dst (
        input valid, rd, is_wr_rd, is_link, pc, inst, result
    );

endinterface

// File: rtl/mem2_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem2_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  logic                is_wr_rd_i,
    input  logic                is_link_i,
    input  logic                is_load_i,
    input  logic                load_unsigned_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  cpu_pkg::reg_idx_t   rd_i,
    input  cpu_pkg::mem_size_t  load_size_i,
    input  cpu_pkg::u32_t       pc_i,
    input  cpu_pkg::u32_t       inst_i,
    input  cpu_pkg::u32_t       ex_result_i,
    input  cpu_pkg::u32_t       mem_rdata_i,
    wb_pass_if.src              out
);
    import cpu_pkg::*;

    logic      valid_q;
    logic      is_wr_rd_q;
    logic      is_link_q;
    logic      is_load_q;
    logic      load_unsigned_q;
    reg_idx_t  rd_q;
    mem_size_t load_size_q;
    u32_t      pc_q;
    u32_t      inst_q;
    u32_t      ex_result_q;
    u32_t      mem_rdata_q;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    u32_t        load_val;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (~stall_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (~stall_i) begin
            is_wr_rd_q      <= is_wr_rd_i;
            is_link_q       <= is_link_i;
            is_load_q       <= is_load_i;
            load_unsigned_q <= load_unsigned_i;
            rd_q            <= rd_i;
            load_size_q     <= load_size_i;
            pc_q            <= pc_i;
            inst_q          <= inst_i;
            ex_result_q     <= ex_result_i;
            mem_rdata_q     <= mem_rdata_i;
        end
    end

    // for a load the ex result is the address, its low bits pick the lane
    assign ld_byte = mem_rdata_q[{ex_result_q[1:0], 3'b000} +: 8];
    assign ld_half = mem_rdata_q[{ex_result_q[1], 4'b0000} +: 16];

    always_comb begin
        case (load_size_q)
            SIZE_BYTE: load_val = {{(`XLEN-8){ld_byte[7] & ~load_unsigned_q}}, ld_byte};
            SIZE_HALF: load_val = {{(`XLEN-16){ld_half[15] & ~load_unsigned_q}}, ld_half};
            SIZE_WORD: load_val = mem_rdata_q;
            default:   load_val = mem_rdata_q;
        endcase
    end

    assign out.valid    = valid_q;
    assign out.rd       = rd_q;
    assign out.is_wr_rd = is_wr_rd_q;
    assign out.is_link  = is_link_q;
    assign out.pc       = pc_q;
    assign out.inst     = inst_q;
    assign out.result   = is_load_q ? load_val : ex_result_q;

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall_i,
    input  logic               flush_i,
    wb_pass_if.dst             in,
    output logic               rf_we_o,
    output cpu_pkg::reg_idx_t  rf_waddr_o,
    output cpu_pkg::u32_t      rf_wdata_o,
    output logic               commit_valid_o,
    output logic               commit_wen_o,
    output cpu_pkg::reg_idx_t  commit_wdest_o,
    output cpu_pkg::u32_t      commit_pc_o,
    output cpu_pkg::u32_t      commit_inst_o,
    output cpu_pkg::u32_t      commit_wdata_o
);
    import cpu_pkg::*;

    logic     valid_q;
    logic     is_wr_rd_q;
    logic     is_link_q;
    reg_idx_t rd_q;
    u32_t     pc_q;
    u32_t     inst_q;
    u32_t     result_q;
    logic     retire;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (~stall_i) begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (~stall_i) begin
            is_wr_rd_q <= in.is_wr_rd;
            is_link_q  <= in.is_link;
            rd_q       <= in.rd;
            pc_q       <= in.pc;
            inst_q     <= in.inst;
            result_q   <= in.result;
        end
    end

    assign retire = valid_q & ~stall_i & ~flush_i;  // a flushed item leaves no trace

    assign rf_waddr_o = rd_q;
    assign rf_wdata_o = is_link_q ? pc_q + 'd4 : result_q;
    // r0 is never written, so it reads zero without a check in the register file
    assign rf_we_o    = retire & is_wr_rd_q & (rd_q != '0);

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            commit_valid_o <= 1'b0;
            commit_wen_o   <= 1'b0;
        end else begin
            commit_valid_o <= retire;
            commit_wen_o   <= rf_we_o;
        end
    end

    always_ff @(posedge clk) begin
        commit_wdest_o <= rf_waddr_o;
        commit_wdata_o <= rf_wdata_o;
        commit_pc_o    <= pc_q;
        commit_inst_o  <= inst_q;
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we_i,
    input  cpu_pkg::reg_idx_t  waddr_i,
    input  cpu_pkg::reg_idx_t  raddr_a_i,
    input  cpu_pkg::reg_idx_t  raddr_b_i,
    input  cpu_pkg::u32_t      wdata_i,
    output cpu_pkg::u32_t      rdata_a_o,
    output cpu_pkg::u32_t      rdata_b_o
);
    import cpu_pkg::*;

    u32_t regs [`NUM_REGS];

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            regs <= '{default: '0};
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // reads see the stored value, a write in the same cycle shows up after the edge
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

// File: rtl/cpu_tail.sv
`timescale 1ns/1ps

module cpu_tail (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  logic                is_wr_rd_i,
    input  logic                is_link_i,
    input  logic                is_load_i,
    input  logic                load_unsigned_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  cpu_pkg::reg_idx_t   rd_i,
    input  cpu_pkg::mem_size_t  load_size_i,
    input  cpu_pkg::u32_t       pc_i,
    input  cpu_pkg::u32_t       inst_i,
    input  cpu_pkg::u32_t       ex_result_i,
    input  cpu_pkg::u32_t       mem_rdata_i,
    input  cpu_pkg::reg_idx_t   raddr_a_i,
    input  cpu_pkg::reg_idx_t   raddr_b_i,
    output cpu_pkg::u32_t       rdata_a_o,
    output cpu_pkg::u32_t       rdata_b_o,
    output logic                commit_valid_o,
    output logic                commit_wen_o,
    output cpu_pkg::reg_idx_t   commit_wdest_o,
    output cpu_pkg::u32_t       commit_pc_o,
    output cpu_pkg::u32_t       commit_inst_o,
    output cpu_pkg::u32_t       commit_wdata_o
);
    import cpu_pkg::*;

    logic     rf_we;
    reg_idx_t rf_waddr;
    u32_t     rf_wdata;

    wb_pass_if u_pass ();  // mem2 to writeback

    mem2_stage u_mem2 (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_i         (valid_i),
        .is_wr_rd_i      (is_wr_rd_i),
        .is_link_i       (is_link_i),
        .is_load_i       (is_load_i),
        .load_unsigned_i (load_unsigned_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .rd_i            (rd_i),
        .load_size_i     (load_size_i),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .ex_result_i     (ex_result_i),
        .mem_rdata_i     (mem_rdata_i),
        .out             (u_pass.src)
    );

    writeback_stage u_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .in             (u_pass.dst),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_wen_o   (commit_wen_o),
        .commit_wdest_o (commit_wdest_o),
        .commit_pc_o    (commit_pc_o),
        .commit_inst_o  (commit_inst_o),
        .commit_wdata_o (commit_wdata_o)
    );

    regfile u_rf (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .raddr_a_i (raddr_a_i),
        .raddr_b_i (raddr_b_i),
        .wdata_i   (rf_wdata),
        .rdata_a_o (rdata_a_o),
        .rdata_b_o (rdata_b_o)
    );

endmodule

// File: tests/cpu_tail_chk.sv
`timescale 1ns/1ps

module cpu_tail_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              stall_i,
    input logic              commit_valid_o,
    input logic              commit_wen_o,
    input cpu_pkg::reg_idx_t commit_wdest_o
);

    int unsigned fail_cnt = 0;  // failed assertions so far

    // nothing retires while the pipeline is held
    stall_no_commit: assert property (
        @(posedge clk) disable iff (!rst_n) stall_i |=> !commit_valid_o
    ) else begin
        fail_cnt++;
        $error("commit_valid_o high after a stalled cycle");
    end

    wen_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_wen_o |-> (commit_valid_o && commit_wdest_o != '0)
    ) else begin
        fail_cnt++;
        $error("commit_wen_o without a valid commit to a non-zero register");
    end

    // first cycle out of reset holds no commit
    quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !commit_valid_o
    ) else begin
        fail_cnt++;
        $error("commit_valid_o high right after reset release");
    end

endmodule

bind cpu_tail cpu_tail_chk u_chk (.*);

// File: tests/cpu_tail_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tail_tb;
    import cpu_pkg::*;

    localparam int MAX_LINES = 64;

    logic      clk;
    logic      rst_n;
    logic      valid_i, is_wr_rd_i, is_link_i, is_load_i, load_unsigned_i, stall_i, flush_i;
    reg_idx_t  rd_i, raddr_a_i, raddr_b_i;
    mem_size_t load_size_i;
    u32_t      pc_i, inst_i, ex_result_i, mem_rdata_i;
    u32_t      rdata_a_o, rdata_b_o, commit_pc_o, commit_inst_o, commit_wdata_o;
    logic      commit_valid_o, commit_wen_o;
    reg_idx_t  commit_wdest_o;

    u32_t f_valid [MAX_LINES];  // one entry per column of the input file
    u32_t f_rd [MAX_LINES];
    u32_t f_wr [MAX_LINES];
    u32_t f_link [MAX_LINES];
    u32_t f_load [MAX_LINES];
    u32_t f_size [MAX_LINES];
    u32_t f_uns [MAX_LINES];
    u32_t f_pc [MAX_LINES];
    u32_t f_inst [MAX_LINES];
    u32_t f_ex [MAX_LINES];
    u32_t f_mem [MAX_LINES];
    u32_t f_stall [MAX_LINES];
    u32_t f_flush [MAX_LINES];
    u32_t f_wdata [MAX_LINES];
    int   n_lines;
    logic lines_loaded;

    int   cur_idx, m2_idx, wb_idx;      // model of the two pipeline slots
    logic cur_valid, cur_stall, cur_flush, m2_v, wb_v;
    int   expect_q [$];                 // retired lines waiting for their commit trace
    u32_t model_regs [`NUM_REGS];

    cpu_tail u_cpu_tail (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input u32_t got, input u32_t exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("tests/cpu_tail_input.txt", "r");
        if (fd == 0) fail_run("could not open the stimulus file");
        n_lines = 0;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != 8'h23) begin  // skip comment lines
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_valid[n_lines], f_rd[n_lines], f_wr[n_lines], f_link[n_lines],
                    f_load[n_lines], f_size[n_lines], f_uns[n_lines], f_pc[n_lines],
                    f_inst[n_lines], f_ex[n_lines], f_mem[n_lines], f_stall[n_lines],
                    f_flush[n_lines], f_wdata[n_lines]);
                if (cnt == 14) n_lines++;
            end
        end
        $fclose(fd);
        lines_loaded = 1'b1;
    endtask

    function automatic logic writes_reg(input int idx);
        return f_wr[idx][0] && (f_rd[idx][4:0] != 5'd0);
    endfunction

    // one rising edge as seen by the pipeline, using the inputs driven before it
    task automatic advance_model();
        if (cur_flush) begin
            m2_v = 1'b0;
            wb_v = 1'b0;
        end else if (!cur_stall) begin
            if (wb_v) begin
                expect_q.push_back(wb_idx);
                if (writes_reg(wb_idx)) model_regs[f_rd[wb_idx][4:0]] = f_wdata[wb_idx];
            end
            wb_v   = m2_v;
            wb_idx = m2_idx;
            m2_v   = cur_valid;
            m2_idx = cur_idx;
        end
    endtask

    task automatic apply_line(input int i);
        valid_i         <= f_valid[i][0];
        rd_i            <= f_rd[i][4:0];
        is_wr_rd_i      <= f_wr[i][0];
        is_link_i       <= f_link[i][0];
        is_load_i       <= f_load[i][0];
        load_size_i     <= f_size[i][1:0];
        load_unsigned_i <= f_uns[i][0];
        pc_i            <= f_pc[i];
        inst_i          <= f_inst[i];
        ex_result_i     <= f_ex[i];
        mem_rdata_i     <= f_mem[i];
        stall_i         <= f_stall[i][0];
        flush_i         <= f_flush[i][0];
        cur_idx   = i;
        cur_valid = f_valid[i][0];
        cur_stall = f_stall[i][0];
        cur_flush = f_flush[i][0];
    endtask

    task automatic apply_idle();
        valid_i <= 1'b0;
        stall_i <= 1'b0;
        flush_i <= 1'b0;
        cur_valid = 1'b0;
        cur_stall = 1'b0;
        cur_flush = 1'b0;
    endtask

    // the commit trace is stable half a cycle after the edge that registered it
    always @(negedge clk) begin
        int idx;
        if (rst_n && commit_valid_o) begin
            if (expect_q.size() == 0) fail_run("a commit appeared with no instruction retiring");
            idx = expect_q.pop_front();
            check_value("commit_pc_o", commit_pc_o, f_pc[idx]);
            check_value("commit_inst_o", commit_inst_o, f_inst[idx]);
            check_value("commit_wen_o", u32_t'(commit_wen_o), u32_t'(writes_reg(idx)));
            check_value("commit_wdata_o", commit_wdata_o, f_wdata[idx]);
            if (commit_wen_o) check_value("commit_wdest_o", u32_t'(commit_wdest_o), f_rd[idx]);
        end else if (rst_n && expect_q.size() != 0) begin
            fail_run("an expected commit did not appear");
        end
    end

    initial begin
        wait (lines_loaded === 1'b1);
        #((n_lines + 20 + `NUM_REGS) * 10);
        fail_run("timeout, the run did not finish in time");
    end

    initial begin
        rst_n           = 1'b0;
        valid_i         = 1'b0;
        is_wr_rd_i      = 1'b0;
        is_link_i       = 1'b0;
        is_load_i       = 1'b0;
        load_unsigned_i = 1'b0;
        stall_i         = 1'b0;
        flush_i         = 1'b0;
        rd_i            = '0;
        load_size_i     = '0;
        pc_i            = '0;
        inst_i          = '0;
        ex_result_i     = '0;
        mem_rdata_i     = '0;
        raddr_a_i       = '0;
        raddr_b_i       = '0;
        lines_loaded    = 1'b0;
        m2_v            = 1'b0;
        wb_v            = 1'b0;
        cur_idx         = 0;
        m2_idx          = 0;
        wb_idx          = 0;
        cur_valid       = 1'b0;
        cur_stall       = 1'b0;
        cur_flush       = 1'b0;
        model_regs      = '{default: '0};
        load_stimulus();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            advance_model();
            apply_line(i);
        end
        repeat (5) begin  // drain the pipeline
            @(posedge clk);
            advance_model();
            apply_idle();
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            @(posedge clk);
            raddr_a_i <= reg_idx_t'(r);
            raddr_b_i <= reg_idx_t'(`NUM_REGS - 1 - r);
            @(negedge clk);
            check_value($sformatf("rdata_a_o[%0d]", r), rdata_a_o, model_regs[r]);
            check_value($sformatf("rdata_b_o[%0d]", `NUM_REGS - 1 - r), rdata_b_o,
                model_regs[`NUM_REGS - 1 - r]);
        end
        if (expect_q.size() != 0) begin
            fail_run("commits were still outstanding at the end");
        end else if (u_cpu_tail.u_chk.fail_cnt != 0) begin
            fail_run("a bound assertion on the commit trace failed during the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: tests/cpu_tail_input.txt
# valid rd wr link load size unsigned pc inst ex_result mem_rdata stall flush exp_wdata (hex)
# exp_wdata is the commit write data expected for the line once it retires
1 01 1 0 0 0 0 00001000 00500093 0000000a 00000000 0 0 0000000a
1 02 1 0 0 0 0 00001004 00a00113 00000014 00000000 0 0 00000014
1 03 1 0 0 0 0 00001008 123451b7 12345678 00000000 0 0 12345678
1 04 1 1 0 0 0 0000100c 000002ef 00002000 00000000 0 0 00001010
1 05 1 0 1 0 0 00001010 00000283 00003000 8091a2f3 0 0 fffffff3
1 06 1 0 1 0 1 00001014 00004303 00003001 8091a2f3 0 0 000000a2
1 07 1 0 1 0 0 00001018 00000383 00003002 8091a2f3 0 0 ffffff91
1 08 1 0 1 0 1 0000101c 00004403 00003003 8091a2f3 0 0 00000080
1 0a 1 0 1 0 0 00001020 00000503 00003001 12345678 0 0 00000056
1 0b 1 0 1 1 0 00001024 00001583 00003000 8091a2f3 0 0 ffffa2f3
1 0c 1 0 1 1 1 00001028 00005603 00003002 8091a2f3 0 0 00008091
1 0d 1 0 1 1 0 0000102c 00001683 00003002 12345678 0 0 00001234
1 0e 1 0 1 1 1 00001030 00005703 00003000 8091a2f3 0 0 0000a2f3
1 0f 1 0 1 2 0 00001034 00002783 00003004 8091a2f3 0 0 8091a2f3
1 00 1 0 0 0 0 00001038 00000013 deadbeef 00000000 0 0 deadbeef
1 10 0 0 0 0 0 0000103c 00000063 cafef00d 00000000 0 0 cafef00d
1 11 1 0 0 0 0 00001040 00000893 11111111 00000000 0 0 11111111
1 12 1 0 0 0 0 00001044 00000913 22222222 00000000 1 0 22222222
0 00 0 0 0 0 0 00000000 00000000 00000000 00000000 1 0 00000000
1 12 1 0 0 0 0 00001044 00000913 22222222 00000000 0 0 22222222
1 13 1 0 0 0 0 00001048 00000993 33333333 00000000 0 0 33333333
1 14 1 0 0 0 0 0000104c 00000a13 44444444 00000000 0 1 44444444
0 00 0 0 0 0 0 00000000 00000000 00000000 00000000 0 0 00000000
1 15 1 0 0 0 0 00001050 00000a93 55555555 00000000 0 0 55555555
1 01 1 0 0 0 0 00001054 00000093 0badf00d 00000000 0 0 0badf00d

// File: cpu_tail.f
+incdir+include
rtl/cpu_pkg.sv
rtl/wb_pass_if.sv
rtl/mem2_stage.sv
rtl/writeback_stage.sv
rtl/regfile.sv
rtl/cpu_tail.sv
tests/cpu_tail_chk.sv
tests/cpu_tail_tb.sv

// File: Bender.yml
package:
  name: cpu_tail

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cpu_pkg.sv
      - rtl/wb_pass_if.sv
      - rtl/mem2_stage.sv
      - rtl/writeback_stage.sv
      - rtl/regfile.sv
      - rtl/cpu_tail.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cpu_tail_chk.sv
      - tests/cpu_tail_tb.sv
